//--- Bender.yml
package:
  name: pcie_fifo

sources:
  - files:
      - hdl/pcie_tlp_pkg.sv
      - hdl/host_fifo_pkg.sv
      - hdl/sync_fifo.sv
      - hdl/pcie_rx.sv
      - hdl/reg_bank.sv
      - hdl/pcie_tx.sv
      - hdl/pcie_fifo_top.sv
  - target: test
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_pcie_fifo.sv

//--- hdl/host_fifo_pkg.sv
// user side definitions of the endpoint
// register bank size, register address and data types
// and the completion word handed to user logic

package host_fifo_pkg;

   localparam int REG_COUNT   = 64;                 // registers in the bank
   localparam int REG_ADDR_W  = $clog2(REG_COUNT);  // qword address into the bank
   localparam int REG_DATA_W  = 64;
   localparam int CPL_TAG_W   = 8;                  // tag of a request and its completion
   localparam int CPL_INDEX_W = 6;                  // qword slot within a completion buffer

   typedef logic [REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [REG_DATA_W-1:0] reg_word_t;

   // one received completion qword with the slot it belongs in
   typedef struct packed {
      logic [CPL_TAG_W-1:0]   tag;
      logic [CPL_INDEX_W-1:0] index;
      reg_word_t              data;
   } cpl_word_t;

endpackage

//--- hdl/pcie_fifo_top.sv
// receive side of the PCIe to FIFO endpoint
// parser, register bank, pending read and completion FIFOs and the completion sender

`timescale 1ns/1ps

module pcie_fifo_top
   import pcie_tlp_pkg::*;
   import host_fifo_pkg::*;
#(
   parameter logic [REQ_ID_W-1:0] COMPLETER_ID = 16'h0100,
   parameter int                  RD_DEPTH     = 4,    // host keeps this many reads in flight
   parameter int                  CPL_DEPTH    = 16
) (
   input  logic       clock,
   input  logic       reset,
   input  logic       rx_valid,
   input  axis_beat_t rx_beat,
   output logic       tx_valid,
   output axis_beat_t tx_beat,
   input  logic       tx_ready,
   input  logic       cpl_pop,
   output cpl_word_t  cpl_word,
   output logic       cpl_empty
);

   logic                   write_valid;
   logic                   read_valid;
   logic                   completion_valid;
   reg_word_t              rx_data;
   reg_addr_t              wr_addr;
   reg_addr_t              rd_addr;
   logic [31:0]            cpl_dw2;
   logic [CPL_TAG_W-1:0]   completion_tag;
   logic [CPL_INDEX_W-1:0] completion_index;
   logic                   rd_push;
   rd_req_t                rd_item;
   rd_req_t                rd_head;
   logic                   rd_empty;
   logic                   rd_pop;
   cpl_word_t              cpl_item;

   pcie_rx u_rx (
      .clock            (clock),
      .reset            (reset),
      .rx_valid         (rx_valid),
      .rx_beat          (rx_beat),
      .write_valid      (write_valid),
      .read_valid       (read_valid),
      .completion_valid (completion_valid),
      .data             (rx_data),
      .wr_addr          (wr_addr),
      .rd_addr          (rd_addr),
      .cpl_dw2          (cpl_dw2),
      .completion_tag   (completion_tag),
      .completion_index (completion_index)
   );

   reg_bank u_reg_bank (
      .clock       (clock),
      .reset       (reset),
      .write_valid (write_valid),
      .read_valid  (read_valid),
      .data        (rx_data),
      .wr_addr     (wr_addr),
      .rd_addr     (rd_addr),
      .cpl_dw2     (cpl_dw2),
      .rd_push     (rd_push),
      .rd_item     (rd_item)
   );

   // pending reads fill up here while the transmit side is held off
   sync_fifo #(.item_t(rd_req_t), .DEPTH(RD_DEPTH)) u_rd_fifo (
      .clock     (clock),
      .reset     (reset),
      .push      (rd_push),
      .pop       (rd_pop),
      .push_item (rd_item),
      .head      (rd_head),
      .full      (),
      .empty     (rd_empty)
   );

   pcie_tx #(.COMPLETER_ID(COMPLETER_ID)) u_tx (
      .clock    (clock),
      .reset    (reset),
      .rd_empty (rd_empty),
      .rd_head  (rd_head),
      .rd_pop   (rd_pop),
      .tx_valid (tx_valid),
      .tx_beat  (tx_beat),
      .tx_ready (tx_ready)
   );

   // each completion qword goes straight into the FIFO in the cycle of its strobe
   assign cpl_item = '{tag: completion_tag, index: completion_index, data: rx_data};

   sync_fifo #(.item_t(cpl_word_t), .DEPTH(CPL_DEPTH)) u_cpl_fifo (
      .clock     (clock),
      .reset     (reset),
      .push      (completion_valid),
      .pop       (cpl_pop),
      .push_item (cpl_item),
      .head      (cpl_word),         // user logic reads the head and then pops
      .full      (),
      .empty     (cpl_empty)
   );

endmodule

//--- hdl/pcie_rx.sv
// receive TLP parser
// registers the stream, tracks header dwords and decodes MWR32, MRD32 and CPLD
// emits write, read and completion strobes with the reassembled payload qword

`timescale 1ns/1ps

module pcie_rx
   import pcie_tlp_pkg::*;
   import host_fifo_pkg::*;
(
   input  logic                   clock,
   input  logic                   reset,
   input  logic                   rx_valid,
   input  axis_beat_t             rx_beat,
   output logic                   write_valid,
   output logic                   read_valid,
   output logic                   completion_valid,
   output reg_word_t              data,
   output reg_addr_t              wr_addr,
   output reg_addr_t              rd_addr,
   output logic [31:0]            cpl_dw2,
   output logic [CPL_TAG_W-1:0]   completion_tag,
   output logic [CPL_INDEX_W-1:0] completion_index
);

   // which pair of dwords the next registered beat carries
   typedef enum logic [1:0] {
      PH_DW01,                      // fmt/type, length, requester id and tag
      PH_DW23,                      // address and the first payload dword
      PH_DW45                       // payload only
   } phase_t;

   phase_t                         phase;
   logic                           rx_valid_q;
   axis_beat_t                     beat_q;
   logic [31:0]                    dw_lo;        // even dword of the registered beat
   logic [31:0]                    dw_hi;        // odd dword of the registered beat
   fmt_type_t                      beat_type;
   logic [31:0]                    prev_dw;      // upper dword of the previous beat
   logic                           is_mwr;
   logic                           is_mrd_1dw;
   logic                           is_cpld;
   logic [REQ_ID_W+CPL_TAG_W-1:0]  rid_tag;      // requester id and tag of a read
   logic [6:2]                     rd_lower_addr;
   reg_addr_t                      addr_q;
   logic [CPL_INDEX_W-1:0]         next_index;   // slot of the next completion qword

   assign dw_lo     = beat_q.data[31:0];
   assign dw_hi     = beat_q.data[63:32];
   assign beat_type = fmt_type_t'(dw_lo[30:24]);

   assign wr_addr = addr_q;
   assign rd_addr = addr_q;
   // completion dword 2 has reserved bit 7 and byte lower address bits 1:0 clear
   assign cpl_dw2 = {rid_tag, 1'b0, rd_lower_addr, 2'b00};

   // input register and phase tracking
   always_ff @(posedge clock)
   begin
      beat_q <= rx_beat;
      if (reset)
      begin
         rx_valid_q       <= 1'b0;
         phase            <= PH_DW01;       // first beat after reset starts a TLP
         is_mwr           <= 1'b0;
         is_mrd_1dw       <= 1'b0;
         is_cpld          <= 1'b0;
         write_valid      <= 1'b0;
         read_valid       <= 1'b0;
         completion_valid <= 1'b0;
      end
      else
      begin
         rx_valid_q       <= rx_valid;
         // each strobe lands two cycles after its beat arrived at the input
         write_valid      <= rx_valid_q && is_mwr && (phase == PH_DW45);
         read_valid       <= rx_valid_q && is_mrd_1dw && (phase == PH_DW23);
         completion_valid <= rx_valid_q && is_cpld && (phase == PH_DW45);
         if (rx_valid_q)
         begin
            if (phase == PH_DW01)
            begin
               is_mwr     <= (beat_type == MWR32);
               is_cpld    <= (beat_type == CPLD);
               is_mrd_1dw <= (beat_type == MRD32) && (dw_lo[LEN_W-1:0] == LEN_W'(1));
            end
            if (beat_q.last)
               phase <= PH_DW01;            // the beat after last opens a new TLP
            else if (phase == PH_DW01)
               phase <= PH_DW23;
            else if (phase == PH_DW23)
               phase <= PH_DW45;            // payload phase lasts until last
         end
      end
   end

   // header fields and payload, qualified by phase only
   always_ff @(posedge clock)
   begin
      if (rx_valid_q)
      begin
         // a payload qword straddles two beats because the header has three dwords
         data    <= {dw_swap(dw_lo), dw_swap(prev_dw)};
         prev_dw <= dw_hi;
         case (phase)
            PH_DW01:
            begin
               if (beat_type == MRD32)
                  rid_tag <= dw_hi[31:8];
               // byte count bits 8:6 of a completion, which are beat bits 40:38
               next_index <= 6'd63 - {dw_hi[8:6], 3'd0};
            end
            PH_DW23:
            begin
               addr_q         <= dw_lo[8:3];    // qword address within the bank
               completion_tag <= dw_lo[15:8];   // only meaningful for a completion
               if (is_mrd_1dw)
                  rd_lower_addr <= dw_lo[6:2];
            end
            default:
            begin
               completion_index <= next_index;
               next_index       <= next_index + 1'b1;   // wraps modulo 64
            end
         endcase
      end
   end

   // a TLP is exactly one of the three kinds so the strobes never overlap
   assert property (@(posedge clock) disable iff (reset)
      $onehot0({write_valid, read_valid, completion_valid}))
      else $error("pcie_rx raised more than one strobe");

endmodule

//--- hdl/pcie_tlp_pkg.sv
// PCI Express TLP definitions for the receive and transmit paths
// fmt/type codes, header field widths, the stream beat and the pending read record
// and the dword byte swap between the core's stream and host order

package pcie_tlp_pkg;

   localparam int REQ_ID_W = 16;   // bus/device/function of requester or completer
   localparam int LEN_W    = 10;   // length field of dword 0, counted in dwords
   localparam int BCNT_W   = 12;   // byte count field of completion dword 1

   localparam logic [2:0] CPL_SC = 3'b000;  // successful completion status

   // fmt and type together as they sit in bits 30:24 of dword 0
   typedef enum logic [6:0] {
      MRD32 = 7'b0000000,           // memory read with a 3 dword header and no data
      MWR32 = 7'b1000000,           // memory write with a 3 dword header and data
      CPLD  = 7'b1001010            // completion with data
   } fmt_type_t;

   // one beat of the 64-bit stream in either direction
   typedef struct packed {
      logic [63:0] data;            // lower dword goes first on the link
      logic        last;            // set on the final beat of a TLP
   } axis_beat_t;

   // one read waiting for its completion to be sent
   typedef struct packed {
      logic [31:0] cpl_dw2;         // requester id, tag and lower address of the completion
      logic [31:0] rd_data;         // register dword in host order
   } rd_req_t;

   // the core presents payload bytes little endian within each dword
   function automatic logic [31:0] dw_swap(input logic [31:0] x);
      return {x[7:0], x[15:8], x[23:16], x[31:24]};
   endfunction

endpackage

//--- hdl/pcie_tx.sv
// completion transmitter
// turns each pending read into a two beat CPLD on the transmit stream
// and holds every beat until the core takes it

`timescale 1ns/1ps

module pcie_tx
   import pcie_tlp_pkg::*;
#(
   parameter logic [REQ_ID_W-1:0] COMPLETER_ID = 16'h0100
) (
   input  logic       clock,
   input  logic       reset,
   input  logic       rd_empty,
   input  rd_req_t    rd_head,
   output logic       rd_pop,
   output logic       tx_valid,
   output axis_beat_t tx_beat,
   input  logic       tx_ready
);

   typedef enum logic [1:0] {
      TX_IDLE,                          // waiting for a pending read
      TX_HDR,                           // dwords 0 and 1 on the stream
      TX_DATA                           // dword 2 and the read data
   } tx_state_t;

   tx_state_t   state;
   logic [31:0] cpl_dw0;
   logic [31:0] cpl_dw1;

   // traffic class, attributes and the TD and EP bits are all zero
   assign cpl_dw0 = {1'b0, CPLD, 14'd0, LEN_W'(1)};
   // one dword read so the byte count is always 4
   assign cpl_dw1 = {COMPLETER_ID, CPL_SC, 1'b0, BCNT_W'(4)};

   always_ff @(posedge clock)
   begin
      if (reset)
         state <= TX_IDLE;
      else
      begin
         case (state)
            TX_IDLE:
               if (!rd_empty)
                  state <= TX_HDR;
            TX_HDR:
               if (tx_ready)
                  state <= TX_DATA;
            TX_DATA:
               if (tx_ready)
                  state <= TX_IDLE;     // FIFO head advances on this edge
            default:
               state <= TX_IDLE;
         endcase
      end
   end

   assign tx_valid = (state != TX_IDLE);
   assign rd_pop   = (state == TX_DATA) && tx_ready;

   // the FIFO head only moves on rd_pop, so the beat stays still while it waits
   always_comb
   begin
      if (state == TX_DATA)
      begin
         tx_beat.data = {dw_swap(rd_head.rd_data), rd_head.cpl_dw2};
         tx_beat.last = 1'b1;
      end
      else
      begin
         tx_beat.data = {cpl_dw1, cpl_dw0};
         tx_beat.last = 1'b0;
      end
   end

   // a beat offered and not taken must be offered again unchanged
   assert property (@(posedge clock) disable iff (reset)
      tx_valid && !tx_ready |=> tx_valid && $stable(tx_beat))
      else $error("pcie_tx changed a beat under back-pressure");

endmodule

//--- hdl/reg_bank.sv
// bank of 64-bit host registers
// applies host writes and turns host reads into pending read records

`timescale 1ns/1ps

module reg_bank
   import pcie_tlp_pkg::*;
   import host_fifo_pkg::*;
(
   input  logic        clock,
   input  logic        reset,
   input  logic        write_valid,
   input  logic        read_valid,
   input  reg_word_t   data,
   input  reg_addr_t   wr_addr,
   input  reg_addr_t   rd_addr,
   input  logic [31:0] cpl_dw2,
   output logic        rd_push,
   output rd_req_t     rd_item
);

   reg_word_t regs [REG_COUNT];
   reg_word_t rd_word;                  // addressed register before dword select

   assign rd_word = regs[rd_addr];

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         for (int i = 0; i < REG_COUNT; i++)
            regs[i] <= '0;              // host sees zeros until it writes
         rd_push <= 1'b0;
      end
      else
      begin
         if (write_valid)
            regs[wr_addr] <= data;
         rd_push <= read_valid;         // record enters the FIFO one cycle after the strobe
      end
   end

   // the pending read record travels with rd_push
   always_ff @(posedge clock)
   begin
      if (read_valid)
      begin
         rd_item.cpl_dw2 <= cpl_dw2;
         // lower address bit 2 picks the odd dword of the qword
         rd_item.rd_data <= cpl_dw2[2] ? rd_word[63:32] : rd_word[31:0];
      end
   end

endmodule

//--- hdl/sync_fifo.sv
// single clock FIFO for any payload type
// circular buffer with fill count, head always visible at the output

`timescale 1ns/1ps

module sync_fifo #(
   parameter type item_t = logic [7:0],
   parameter int  DEPTH  = 4
) (
   input  logic  clock,
   input  logic  reset,
   input  logic  push,
   input  logic  pop,
   input  item_t push_item,
   output item_t head,
   output logic  full,
   output logic  empty
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   item_t            mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;             // items held
   logic             do_push;
   logic             do_pop;

   // pointers wrap at DEPTH so any depth works
   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign full    = (count == CNT_W'(DEPTH));
   assign empty   = (count == '0);
   assign do_push = push && !full;     // an illegal push or pop leaves the state alone
   assign do_pop  = pop && !empty;
   assign head    = mem[rd_ptr];

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= ptr_next(wr_ptr);
         if (do_pop)
            rd_ptr <= ptr_next(rd_ptr);
         if (do_push && !do_pop)
            count <= count + 1'b1;
         else if (do_pop && !do_push)
            count <= count - 1'b1;
      end
   end

   always_ff @(posedge clock)
   begin
      if (do_push)
         mem[wr_ptr] <= push_item;
   end

   // the producer must respect full and the consumer must respect empty
   assert property (@(posedge clock) disable iff (reset) push |-> !full)
      else $error("sync_fifo push while full");
   assert property (@(posedge clock) disable iff (reset) pop |-> !empty)
      else $error("sync_fifo pop while empty");

endmodule

//--- sim/tb_clock_gen.sv
// testbench clock and synchronous reset source
// 8 ns clock period, reset held high for the first 16 rising edges

`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int HALF_PERIOD  = 4,      // in ns
   parameter int RESET_CYCLES = 16
) (
   output logic clock,
   output logic reset
);

   initial
   begin
      clock = 1'b0;
      forever
         #HALF_PERIOD clock = ~clock;
   end

   initial
   begin
      reset = 1'b1;
      repeat (RESET_CYCLES)
         @(posedge clock);
      reset <= 1'b0;                    // released on an edge like any other input
   end

endmodule

//--- sim/tb_pcie_fifo.sv
// directed testbench for the PCIe receive endpoint
// builds TLPs beat by beat, models the register bank and watches the transmit stream
// compares completions on the transmit side and the completion FIFO on the user side

`timescale 1ns/1ps

module tb_pcie_fifo
   import pcie_tlp_pkg::*;
   import host_fifo_pkg::*;
();

   localparam logic [15:0] COMPLETER_ID = 16'h0308;      // id of the endpoint
   localparam logic [15:0] HOST_ID      = 16'h0010;      // id of the root port
   localparam logic [15:0] PEER_ID      = 16'h0400;      // completer of our own requests
   localparam logic [31:0] BAR_BASE     = 32'hF000_0000;
   localparam int          TIMEOUT      = 200;           // cycles allowed for any wait
   localparam logic [1:0]  FMT_NO_DATA  = 2'b00;         // 3 dword header without payload
   localparam logic [1:0]  FMT_DATA     = 2'b10;         // 3 dword header with payload
   localparam logic [4:0]  TYPE_MEM     = 5'b00000;
   localparam logic [4:0]  TYPE_CPL     = 5'b01010;

   logic       clock;
   logic       reset;
   logic       rx_valid;
   axis_beat_t rx_beat;
   logic       tx_valid;
   axis_beat_t tx_beat;
   logic       tx_ready;
   logic       cpl_pop;
   cpl_word_t  cpl_word;
   logic       cpl_empty;

   int          value_errors;
   int          protocol_errors;        // timeouts and stray traffic
   integer      seed;
   reg_word_t   reg_model [REG_COUNT];  // what the host believes the registers hold
   logic [31:0] tlp_dw [$];             // dwords of the TLP being built
   axis_beat_t  rx_queue [$];           // beats waiting to be driven
   axis_beat_t  tx_seen [$];            // beats the core accepted from the DUT
   axis_beat_t  held_beat;
   logic        held;
   reg_word_t   cpl_payload [4];

   tb_clock_gen u_clock_gen (
      .clock (clock),
      .reset (reset)
   );

   pcie_fifo_top #(
      .COMPLETER_ID (COMPLETER_ID),
      .RD_DEPTH     (4),
      .CPL_DEPTH    (16)
   ) u_dut (
      .clock     (clock),
      .reset     (reset),
      .rx_valid  (rx_valid),
      .rx_beat   (rx_beat),
      .tx_valid  (tx_valid),
      .tx_beat   (tx_beat),
      .tx_ready  (tx_ready),
      .cpl_pop   (cpl_pop),
      .cpl_word  (cpl_word),
      .cpl_empty (cpl_empty)
   );

   // payload bytes travel little endian within each dword on the core's stream
   function automatic logic [31:0] swap_bytes(input logic [31:0] x);
      return {x[7:0], x[15:8], x[23:16], x[31:24]};
   endfunction

   // dword 0 with traffic class, attributes, TD and EP all zero
   function automatic logic [31:0] header_dw0(input logic [1:0] fmt, input logic [4:0] kind,
                                              input logic [9:0] len);
      return {1'b0, fmt, kind, 14'd0, len};
   endfunction

   function automatic logic [31:0] byte_addr(input reg_addr_t a, input logic odd);
      return BAR_BASE | {23'd0, a, odd, 2'b00};   // odd selects the upper dword of the qword
   endfunction

   task automatic check_beat(input axis_beat_t actual, input axis_beat_t expected,
                             input string what);
      if (actual !== expected)
      begin
         value_errors++;
         $display("[ERROR] time %0t: %s beat is %h last %b, expected %h last %b", $time, what,
                  actual.data, actual.last, expected.data, expected.last);
      end
   endtask

   task automatic check_cpl(input cpl_word_t actual, input cpl_word_t expected,
                            input string what);
      if (actual !== expected)
      begin
         value_errors++;
         $display("[ERROR] time %0t: %s tag %h idx %0d data %h, expected tag %h idx %0d data %h",
                  $time, what, actual.tag, actual.index, actual.data,
                  expected.tag, expected.index, expected.data);
      end
   endtask

   // watches the transmit stream at the falling edge where every signal has settled
   always @(negedge clock)
   begin
      if (reset)
         held = 1'b0;
      else
      begin
         if (held)
         begin
            if (!tx_valid)
            begin
               value_errors++;
               $display("[ERROR] time %0t: tx_valid dropped while a beat waited", $time);
            end
            check_beat(tx_beat, held_beat, "held");   // a refused beat comes back unchanged
         end
         if (tx_valid && tx_ready)
            tx_seen.push_back(tx_beat);                // taken at the next rising edge
         held      = tx_valid && !tx_ready;
         held_beat = tx_beat;
      end
   end

   // splits the dword list into beats, lower dword first, last on the final one
   task automatic pack_tlp();
      axis_beat_t beat;
      if (tlp_dw.size() % 2 != 0)
         tlp_dw.push_back(32'h0);
      while (tlp_dw.size() > 0)
      begin
         beat.data[31:0]  = tlp_dw.pop_front();
         beat.data[63:32] = tlp_dw.pop_front();
         beat.last        = (tlp_dw.size() == 0);
         rx_queue.push_back(beat);
      end
   endtask

   task automatic queue_write(input reg_addr_t a, input reg_word_t value, input logic [7:0] tag);
      tlp_dw.push_back(header_dw0(FMT_DATA, TYPE_MEM, 10'd2));
      tlp_dw.push_back({HOST_ID, tag, 8'hFF});           // all byte enables on
      tlp_dw.push_back(byte_addr(a, 1'b0));
      tlp_dw.push_back(swap_bytes(value[31:0]));
      tlp_dw.push_back(swap_bytes(value[63:32]));
      pack_tlp();
      reg_model[a] = value;
   endtask

   task automatic queue_read(input reg_addr_t a, input logic odd, input logic [7:0] tag);
      tlp_dw.push_back(header_dw0(FMT_NO_DATA, TYPE_MEM, 10'd1));
      tlp_dw.push_back({HOST_ID, tag, 8'h0F});           // single dword so no last byte enables
      tlp_dw.push_back(byte_addr(a, odd));
      pack_tlp();
   endtask

   // four qwords answering a request of ours; bits 40:38 of beat 1 pick the slot group
   task automatic queue_cpld(input logic [7:0] tag, input logic [2:0] group);
      tlp_dw.push_back(header_dw0(FMT_DATA, TYPE_CPL, 10'd8));
      tlp_dw.push_back({PEER_ID, 3'b000, 1'b0, 3'b000, group, 6'd0});
      tlp_dw.push_back({COMPLETER_ID, tag, 8'h00});
      for (int k = 0; k < 4; k++)
      begin
         tlp_dw.push_back(swap_bytes(cpl_payload[k][31:0]));
         tlp_dw.push_back(swap_bytes(cpl_payload[k][63:32]));
      end
      pack_tlp();
   endtask

   // beats go out back to back, then the stream goes idle
   task automatic drive_rx();
      while (rx_queue.size() > 0)
      begin
         @(posedge clock);
         rx_valid <= 1'b1;
         rx_beat  <= rx_queue.pop_front();
      end
      @(posedge clock);
      rx_valid <= 1'b0;
      rx_beat  <= '0;
   endtask

   task automatic wait_tx_valid();
      int n;
      n = 0;
      @(negedge clock);
      while (!tx_valid && n < TIMEOUT)
      begin
         @(negedge clock);
         n++;
      end
      if (!tx_valid)
      begin
         protocol_errors++;
         $display("timeout: the DUT never offered a completion on the transmit stream");
      end
   endtask

   // two accepted beats form one CPLD whose fields follow the completion format
   task automatic expect_completion(input reg_addr_t a, input logic odd, input logic [7:0] tag);
      axis_beat_t  exp_hdr;
      axis_beat_t  exp_data;
      logic [31:0] dword;
      logic [31:0] addr;
      int          n;
      dword         = odd ? reg_model[a][63:32] : reg_model[a][31:0];
      addr          = byte_addr(a, odd);
      exp_hdr.data  = {COMPLETER_ID, 3'b000, 1'b0, 12'd4, header_dw0(FMT_DATA, TYPE_CPL, 10'd1)};
      exp_hdr.last  = 1'b0;
      exp_data.data = {swap_bytes(dword), HOST_ID, tag, 1'b0, addr[6:0]};
      exp_data.last = 1'b1;
      n = 0;
      while (tx_seen.size() < 2 && n < TIMEOUT)
      begin
         @(negedge clock);
         n++;
      end
      if (tx_seen.size() < 2)
      begin
         protocol_errors++;
         $display("timeout: completion for tag %h did not arrive", tag);
         tx_seen.delete();
      end
      else
      begin
         check_beat(tx_seen.pop_front(), exp_hdr, "completion header");
         check_beat(tx_seen.pop_front(), exp_data, "completion data");
      end
   endtask

   task automatic pop_cpl(input cpl_word_t expected);
      int n;
      n = 0;
      @(negedge clock);
      while (cpl_empty && n < TIMEOUT)
      begin
         @(negedge clock);
         n++;
      end
      if (cpl_empty)
      begin
         protocol_errors++;
         $display("timeout: completion FIFO stayed empty, expected index %0d", expected.index);
      end
      else
      begin
         check_cpl(cpl_word, expected, "completion FIFO head");
         @(posedge clock);
         cpl_pop <= 1'b1;
         @(posedge clock);
         cpl_pop <= 1'b0;                   // exactly one pop
      end
   endtask

   task automatic test_reset_state();
      int i;
      for (i = 0; i < 20; i++)
      begin
         @(negedge clock);
         if (tx_valid || !cpl_empty)
         begin
            value_errors++;
            $display("[ERROR] time %0t: tx_valid %b cpl_empty %b while idle after reset",
                     $time, tx_valid, cpl_empty);
         end
      end
      queue_read(6'd9, 1'b0, 8'h01);        // register 9 is never written before this
      queue_read(6'd9, 1'b1, 8'h02);
      drive_rx();
      expect_completion(6'd9, 1'b0, 8'h01);
      expect_completion(6'd9, 1'b1, 8'h02);
   endtask

   task automatic test_write_read();
      queue_write(6'd5, 64'h0123_4567_89AB_CDEF, 8'h10);
      queue_read(6'd5, 1'b0, 8'h11);
      queue_read(6'd5, 1'b1, 8'h12);
      drive_rx();
      expect_completion(6'd5, 1'b0, 8'h11);
      expect_completion(6'd5, 1'b1, 8'h12);
   endtask

   task automatic test_backpressure();
      int i;
      for (i = 0; i < 4; i++)
         queue_write(reg_addr_t'(20 + i), {32'hC0DE_0000 + i, 32'h5EED_0000 + i}, 8'h20);
      drive_rx();
      @(posedge clock);
      tx_ready <= 1'b0;
      for (i = 0; i < 4; i++)
         queue_read(reg_addr_t'(20 + i), i[0], 8'h30 + 8'(i));
      drive_rx();
      wait_tx_valid();
      repeat (12)
         @(negedge clock);                  // the monitor checks the held beat each cycle
      @(posedge clock);
      tx_ready <= 1'b1;                     // the header of the first completion is taken
      @(posedge clock);
      tx_ready <= 1'b0;                     // its data beat now has to wait as well
      repeat (6)
         @(negedge clock);
      @(posedge clock);
      tx_ready <= 1'b1;
      for (i = 0; i < 4; i++)
         expect_completion(reg_addr_t'(20 + i), i[0], 8'h30 + 8'(i));
   endtask

   // index starts at 63 minus eight times the group and counts up modulo 64
   task automatic test_incoming_cpl(input logic [7:0] tag, input logic [2:0] group);
      cpl_word_t   expected;
      logic [5:0]  index;
      int          k;
      for (k = 0; k < 4; k++)
         cpl_payload[k] = {$random(seed), $random(seed)};
      queue_cpld(tag, group);
      drive_rx();
      index = 6'd63 - {group, 3'b000};
      for (k = 0; k < 4; k++)
      begin
         expected.tag   = tag;
         expected.index = index;
         expected.data  = cpl_payload[k];
         pop_cpl(expected);
         index = index + 6'd1;
      end
      @(negedge clock);
      if (!cpl_empty)
      begin
         protocol_errors++;
         $display("completion FIFO still holds data after four qwords were popped");
      end
   endtask

   task automatic test_random_mix(input int count);
      logic [31:0] r;
      reg_addr_t   a;
      reg_addr_t   last_addr;
      logic [7:0]  tag;
      int          i;
      last_addr = '0;
      for (i = 0; i < count; i++)
      begin
         r   = $random(seed);
         tag = 8'h40 + 8'(i);
         a   = r[9] ? last_addr : r[5:0];   // reads often hit the register just written
         if (r[8])
         begin
            queue_write(a, {$random(seed), $random(seed)}, tag);
            drive_rx();
            last_addr = a;
         end
         else
         begin
            queue_read(a, r[6], tag);
            drive_rx();
            expect_completion(a, r[6], tag);
         end
      end
   endtask

   initial
   begin
      int i;
      int n;
      rx_valid        = 1'b0;
      rx_beat         = '0;
      tx_ready        = 1'b1;
      cpl_pop         = 1'b0;
      value_errors    = 0;
      protocol_errors = 0;
      seed            = 41;
      for (i = 0; i < REG_COUNT; i++)
         reg_model[i] = '0;

      n = 0;
      @(negedge clock);
      while (reset && n < TIMEOUT)
      begin
         @(negedge clock);
         n++;
      end
      if (reset)
      begin
         protocol_errors++;
         $display("reset was never released");
      end

      test_reset_state();
      test_write_read();
      test_backpressure();
      test_incoming_cpl(8'h5A, 3'd0);       // 63 then wraps to 0, 1, 2
      test_incoming_cpl(8'hA7, 3'd3);
      test_random_mix(40);

      repeat (4)
         @(negedge clock);
      if (tx_seen.size() != 0)
      begin
         protocol_errors++;
         $display("transmit stream carried %0d beats that no read asked for", tx_seen.size());
      end

      $display("value errors: %0d, protocol errors and timeouts: %0d",
               value_errors, protocol_errors);
      if (value_errors == 0 && protocol_errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

//--- sources.f
hdl/pcie_tlp_pkg.sv
hdl/host_fifo_pkg.sv
hdl/sync_fifo.sv
hdl/pcie_rx.sv
hdl/reg_bank.sv
hdl/pcie_tx.sv
hdl/pcie_fifo_top.sv
sim/tb_clock_gen.sv
sim/tb_pcie_fifo.sv
